//--- source/branch_pkg.sv
// shared widths, flag encoding and opcode sets for the branch resolution subsystem
// every module refers to these by scoped name, the top level takes its parameter
// defaults from here
`default_nettype none

package branch_pkg;

    // instruction address
    typedef logic [31:0] pc_t;
    // compare operand, signed integer or ieee single precision
    typedef logic [31:0] data_t;
    // compare result held by the branch unit
    typedef logic [1:0] flag_t;

    // flag codes, msb set means the operands differ in order
    localparam flag_t FLAG_EQUAL     = 2'b00;
    localparam flag_t FLAG_UNORDERED = 2'b01;
    localparam flag_t FLAG_LESS      = 2'b10;
    localparam flag_t FLAG_GREATER   = 2'b11;

    // compare latencies in cycles, counted as busy cycles
    localparam int INT_CMP_CYCLES   = 2;
    localparam int FLOAT_CMP_CYCLES = 4;

    // program counter after reset
    localparam pc_t RESET_PC = 32'h0000_0000;

    // conditional and unconditional branch opcodes
    typedef enum logic [2:0] {
        bne      = 3'b000,
        bg       = 3'b001,
        bl       = 3'b010,
        bge      = 3'b011,
        ble      = 3'b100,
        reserved = 3'b101,
        jmp      = 3'b110,
        ret      = 3'b111
    } branch_op_e;

    // next pc source, 01 is never produced
    typedef enum logic [1:0] {
        pc_seq  = 2'b00,
        pc_rel  = 2'b10,
        pc_link = 2'b11
    } pc_sel_e;

    // what the issue port is presenting
    typedef enum logic [1:0] {
        other     = 2'b00,
        cmp_int   = 2'b01,
        cmp_float = 2'b10,
        branch    = 2'b11
    } instr_kind_e;

    // stall fsm of the branch unit
    typedef enum logic {
        idle    = 1'b0,
        waiting = 1'b1
    } branch_state_e;

endpackage

`default_nettype wire

//--- source/compare_unit.sv
// multi-cycle comparator for signed integers and single precision floats
// start loads the latency counter and captures both operands, busy stays high
// until the result is out, and the last busy cycle pulses the matching flag enable
`timescale 1ns/1ps
`default_nettype none

module compare_unit #(
    parameter int INT_CMP_CYCLES   = branch_pkg::INT_CMP_CYCLES,
    parameter int FLOAT_CMP_CYCLES = branch_pkg::FLOAT_CMP_CYCLES
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start,
    input  logic                is_float,
    input  branch_pkg::data_t   operand_a,
    input  branch_pkg::data_t   operand_b,
    output logic                busy,
    output logic                int_flag_en,
    output logic                float_flag_en,
    output branch_pkg::flag_t   cmp_flag
);

    localparam int MAX_CYCLES = (INT_CMP_CYCLES > FLOAT_CMP_CYCLES) ?
                                INT_CMP_CYCLES : FLOAT_CMP_CYCLES;
    localparam int CNT_W = (MAX_CYCLES > 1) ? $clog2(MAX_CYCLES) : 1;

    logic [CNT_W-1:0]  cnt;
    logic              float_q;
    logic              done;
    branch_pkg::data_t op_a_q;
    branch_pkg::data_t op_b_q;
    branch_pkg::flag_t int_flag;
    branch_pkg::flag_t float_flag;
    logic              a_nan;
    logic              b_nan;

    // counter runs down to zero, the zero cycle is the result cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            cnt     <= '0;
            float_q <= 1'b0;
        end else if (busy) begin
            if (cnt == '0)
                busy <= 1'b0;
            else
                cnt <= cnt - 1'b1;
        end else if (start) begin
            busy    <= 1'b1;
            float_q <= is_float;
            cnt     <= is_float ? CNT_W'(FLOAT_CMP_CYCLES - 1) : CNT_W'(INT_CMP_CYCLES - 1);
        end
    end

    // operands held for the whole operation
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            op_a_q <= operand_a;
            op_b_q <= operand_b;
        end
    end

    assign done          = busy && (cnt == '0);
    assign int_flag_en   = done && !float_q;
    assign float_flag_en = done && float_q;

    // signed integer order
    always_comb begin
        if (op_a_q == op_b_q)
            int_flag = branch_pkg::FLAG_EQUAL;
        else if ($signed(op_a_q) < $signed(op_b_q))
            int_flag = branch_pkg::FLAG_LESS;
        else
            int_flag = branch_pkg::FLAG_GREATER;
    end

    // nan has an all-ones exponent and a nonzero mantissa
    assign a_nan = (&op_a_q[30:23]) && (|op_a_q[22:0]);
    assign b_nan = (&op_b_q[30:23]) && (|op_b_q[22:0]);

    // sign-magnitude order, magnitudes compare as plain integers
    always_comb begin
        if (a_nan || b_nan)
            float_flag = branch_pkg::FLAG_UNORDERED;
        else if ((op_a_q[30:0] == '0) && (op_b_q[30:0] == '0))
            // +0 and -0 are the same value
            float_flag = branch_pkg::FLAG_EQUAL;
        else if (op_a_q == op_b_q)
            float_flag = branch_pkg::FLAG_EQUAL;
        else if (op_a_q[31] != op_b_q[31])
            float_flag = op_a_q[31] ? branch_pkg::FLAG_LESS : branch_pkg::FLAG_GREATER;
        else if (!op_a_q[31])
            float_flag = (op_a_q[30:0] < op_b_q[30:0]) ?
                         branch_pkg::FLAG_LESS : branch_pkg::FLAG_GREATER;
        else
            // both negative so a larger magnitude is the smaller value
            float_flag = (op_a_q[30:0] > op_b_q[30:0]) ?
                         branch_pkg::FLAG_LESS : branch_pkg::FLAG_GREATER;
    end

    assign cmp_flag = float_q ? float_flag : int_flag;

endmodule

`default_nettype wire

//--- source/branch_unit.sv
// branch resolution and issue stall control
// holds the last compare flag, turns a branch opcode into a next pc select and
// stalls issue while a branch or compare depends on a compare still in flight
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     instr_valid,
    input  branch_pkg::instr_kind_e  instr_kind,
    input  branch_pkg::branch_op_e   branch_opcode,
    input  logic                     cmp_busy,
    input  logic                     int_flag_en,
    input  logic                     float_flag_en,
    input  branch_pkg::flag_t        cmp_flag,
    output logic                     stall,
    output logic                     advance,
    output logic                     cmp_start,
    output branch_pkg::pc_sel_e      next_pc_select
);

    branch_pkg::branch_state_e state;
    branch_pkg::branch_state_e next_state;
    branch_pkg::flag_t         flag;
    branch_pkg::pc_sel_e       branch_sel;
    logic                      flag_updated;
    logic                      is_branch;
    logic                      is_cmp;
    logic                      f_eq;
    logic                      f_lt;
    logic                      f_gt;

    assign is_branch = instr_valid && (instr_kind == branch_pkg::branch);
    assign is_cmp    = instr_valid && ((instr_kind == branch_pkg::cmp_int) ||
                                       (instr_kind == branch_pkg::cmp_float));

    // flag only changes on a finished compare
    // flag_updated remembers that the previous cycle delivered one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= branch_pkg::idle;
            flag         <= branch_pkg::FLAG_EQUAL;
            flag_updated <= 1'b0;
        end else begin
            state        <= next_state;
            flag_updated <= int_flag_en || float_flag_en;
            if (int_flag_en || float_flag_en)
                flag <= cmp_flag;
        end
    end

    assign f_eq = (flag == branch_pkg::FLAG_EQUAL);
    assign f_lt = (flag == branch_pkg::FLAG_LESS);
    assign f_gt = (flag == branch_pkg::FLAG_GREATER);

    // unordered is neither eq, lt nor gt, so only bne sees it as taken
    always_comb begin
        case (branch_opcode)
            branch_pkg::bne: branch_sel = !f_eq ? branch_pkg::pc_rel : branch_pkg::pc_seq;
            branch_pkg::bg:  branch_sel = f_gt ? branch_pkg::pc_rel : branch_pkg::pc_seq;
            branch_pkg::bl:  branch_sel = f_lt ? branch_pkg::pc_rel : branch_pkg::pc_seq;
            branch_pkg::bge: branch_sel = (f_gt || f_eq) ? branch_pkg::pc_rel : branch_pkg::pc_seq;
            branch_pkg::ble: branch_sel = (f_lt || f_eq) ? branch_pkg::pc_rel : branch_pkg::pc_seq;
            branch_pkg::jmp: branch_sel = branch_pkg::pc_rel;
            branch_pkg::ret: branch_sel = branch_pkg::pc_link;
            default:         branch_sel = branch_pkg::pc_seq;
        endcase
    end

    // non-branch instructions always fall through
    assign next_pc_select = (instr_kind == branch_pkg::branch) ? branch_sel : branch_pkg::pc_seq;

    always_comb begin
        stall      = 1'b0;
        next_state = state;
        // a busy comparator holds back anything that depends on it
        if (cmp_busy && (is_branch || is_cmp))
            stall = 1'b1;

        case (state)
            branch_pkg::idle: begin
                // branch arrives while the compare is running
                if (is_branch && cmp_busy)
                    next_state = branch_pkg::waiting;
            end
            branch_pkg::waiting: begin
                if (!is_branch) begin
                    next_state = branch_pkg::idle;
                end else if (!cmp_busy) begin
                    next_state = branch_pkg::idle;
                    // ret does not read the flag and goes at once
                    // a fresh flag costs one more cycle before the branch resolves
                    stall = flag_updated && (branch_opcode != branch_pkg::ret);
                end
            end
            default: next_state = branch_pkg::idle;
        endcase
    end

    assign advance   = instr_valid && !stall;
    assign cmp_start = advance && is_cmp;

endmodule

`default_nettype wire

//--- source/pc_sequencer.sv
// program counter and link register
// the pc moves only on advance, to pc+4, pc+4+offset or the link register
// save_link on an accepted jmp stores the return address pc+4
`timescale 1ns/1ps
`default_nettype none

module pc_sequencer #(
    parameter branch_pkg::pc_t RESET_PC = branch_pkg::RESET_PC
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 advance,
    input  branch_pkg::pc_sel_e  next_pc_select,
    input  branch_pkg::pc_t      branch_offset,
    input  logic                 save_link,
    output branch_pkg::pc_t      pc,
    output branch_pkg::pc_t      link_pc
);

    branch_pkg::pc_t pc_plus4;
    branch_pkg::pc_t pc_target;
    branch_pkg::pc_t next_pc;

    assign pc_plus4  = pc + 32'd4;
    // relative target is taken from the following instruction
    assign pc_target = pc_plus4 + branch_offset;

    always_comb begin
        case (next_pc_select)
            branch_pkg::pc_seq:  next_pc = pc_plus4;
            branch_pkg::pc_rel:  next_pc = pc_target;
            branch_pkg::pc_link: next_pc = link_pc;
            // unused code falls through
            default:             next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (advance) begin
            pc <= next_pc;
        end
    end

    // return address for the next ret
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            link_pc <= '0;
        end else if (advance && save_link) begin
            link_pc <= pc_plus4;
        end
    end

endmodule

`default_nettype wire

//--- source/branch_subsystem.sv
// top level of the branch resolution subsystem
// one instruction per cycle comes in on the issue port and is held while stall is high
// compares go to the comparator, branches resolve in the branch unit and the pc
// sequencer follows the selected next pc
`timescale 1ns/1ps
`default_nettype none

module branch_subsystem #(
    parameter int              INT_CMP_CYCLES   = branch_pkg::INT_CMP_CYCLES,
    parameter int              FLOAT_CMP_CYCLES = branch_pkg::FLOAT_CMP_CYCLES,
    parameter branch_pkg::pc_t RESET_PC         = branch_pkg::RESET_PC
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     instr_valid,
    input  branch_pkg::instr_kind_e  instr_kind,
    input  branch_pkg::branch_op_e   branch_opcode,
    input  branch_pkg::pc_t          branch_offset,
    input  branch_pkg::data_t        operand_a,
    input  branch_pkg::data_t        operand_b,
    output branch_pkg::pc_t          pc,
    output branch_pkg::pc_t          link_pc,
    output logic                     stall
);

    logic                 cmp_start;
    logic                 cmp_busy;
    logic                 int_flag_en;
    logic                 float_flag_en;
    logic                 advance;
    logic                 save_link;
    logic                 is_float;
    branch_pkg::flag_t    cmp_flag;
    branch_pkg::pc_sel_e  next_pc_select;

    // float compares take the longer path in the comparator
    assign is_float = (instr_kind == branch_pkg::cmp_float);

    // only a retiring jmp writes the link register
    assign save_link = advance && (instr_kind == branch_pkg::branch) &&
                       (branch_opcode == branch_pkg::jmp);

    compare_unit #(
        .INT_CMP_CYCLES   (INT_CMP_CYCLES),
        .FLOAT_CMP_CYCLES (FLOAT_CMP_CYCLES)
    ) u_compare_unit (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (cmp_start),
        .is_float      (is_float),
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .busy          (cmp_busy),
        .int_flag_en   (int_flag_en),
        .float_flag_en (float_flag_en),
        .cmp_flag      (cmp_flag)
    );

    branch_unit u_branch_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_valid    (instr_valid),
        .instr_kind     (instr_kind),
        .branch_opcode  (branch_opcode),
        .cmp_busy       (cmp_busy),
        .int_flag_en    (int_flag_en),
        .float_flag_en  (float_flag_en),
        .cmp_flag       (cmp_flag),
        .stall          (stall),
        .advance        (advance),
        .cmp_start      (cmp_start),
        .next_pc_select (next_pc_select)
    );

    pc_sequencer #(
        .RESET_PC (RESET_PC)
    ) u_pc_sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .advance        (advance),
        .next_pc_select (next_pc_select),
        .branch_offset  (branch_offset),
        .save_link      (save_link),
        .pc             (pc),
        .link_pc        (link_pc)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// clock and reset source for the branch subsystem testbench
// 100 ns clock, reset held low for the first 3 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // clk starts low so the release lands on a falling edge
    initial begin
        rst_n = 1'b0;
        #(PERIOD_NS * RESET_CYCLES);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/branch_subsystem_assertions.sv
// concurrent checks on stall, pc and flag enable behavior of the branch subsystem
// bound into branch_subsystem by the testbench
// fail_count tallies failed checks for the testbench summary
`timescale 1ns/1ps
`default_nettype none

module branch_subsystem_assertions (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     instr_valid,
    input branch_pkg::instr_kind_e  instr_kind,
    input logic                     stall,
    input logic                     cmp_busy,
    input logic                     cmp_start,
    input logic                     advance,
    input logic                     save_link,
    input logic                     int_flag_en,
    input logic                     float_flag_en,
    input branch_pkg::pc_t          pc,
    input branch_pkg::pc_t          link_pc
);

    int unsigned fail_count = 0;
    logic        depends_on_cmp;

    // branches and compares both wait for a running compare
    assign depends_on_cmp = instr_valid && ((instr_kind == branch_pkg::branch) ||
                            (instr_kind == branch_pkg::cmp_int) ||
                            (instr_kind == branch_pkg::cmp_float));

    a_stall_on_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (cmp_busy && depends_on_cmp) |-> stall)
        else begin
            $error("stall low while a dependent instruction meets a busy comparator");
            fail_count++;
        end

    // stall only ever holds back a presented instruction
    a_stall_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> instr_valid)
        else begin
            $error("stall high with no instruction on the issue port");
            fail_count++;
        end

    a_pc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !advance |=> $stable(pc))
        else begin
            $error("pc changed in a cycle without advance");
            fail_count++;
        end

    a_link_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !save_link |=> $stable(link_pc))
        else begin
            $error("link register changed without an accepted jmp");
            fail_count++;
        end

    // integer result arrives on the last of its busy cycles, on the integer enable only
    a_int_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (cmp_start && (instr_kind == branch_pkg::cmp_int)) |->
            ##(branch_pkg::INT_CMP_CYCLES) (int_flag_en && !float_flag_en))
        else begin
            $error("integer compare did not pulse int_flag_en after its latency");
            fail_count++;
        end

    a_float_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (cmp_start && (instr_kind == branch_pkg::cmp_float)) |->
            ##(branch_pkg::FLOAT_CMP_CYCLES) (float_flag_en && !int_flag_en))
        else begin
            $error("float compare did not pulse float_flag_en after its latency");
            fail_count++;
        end

    // the pulse is the last busy cycle
    a_flag_en_ends_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (int_flag_en || float_flag_en) |=> !cmp_busy)
        else begin
            $error("comparator still busy after its flag enable");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- testbench/branch_subsystem_tb.sv
// testbench for the branch subsystem
// issues instructions on the falling edge, keeps its own pc, link and flag model,
// and checks pc and link_pc after every accepted instruction
`timescale 1ns/1ps
`default_nettype none

module branch_subsystem_tb;

    localparam int              SETTLE_NS     = 10;
    localparam int              ISSUE_TIMEOUT = 20;
    localparam branch_pkg::data_t QNAN        = 32'h7fc0_0000;
    localparam branch_pkg::data_t NEG_ZERO    = 32'h8000_0000;

    logic                    clk;
    logic                    rst_n;
    logic                    instr_valid;
    branch_pkg::instr_kind_e instr_kind;
    branch_pkg::branch_op_e  branch_opcode;
    branch_pkg::pc_t         branch_offset;
    branch_pkg::data_t       operand_a;
    branch_pkg::data_t       operand_b;
    branch_pkg::pc_t         pc;
    branch_pkg::pc_t         link_pc;
    logic                    stall;

    // reference state
    branch_pkg::pc_t         exp_pc;
    branch_pkg::pc_t         exp_link;
    branch_pkg::flag_t       exp_flag;
    integer                  seed;
    int                      errors;
    int                      timeouts;

    tb_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

    branch_subsystem #(
        .INT_CMP_CYCLES   (branch_pkg::INT_CMP_CYCLES),
        .FLOAT_CMP_CYCLES (branch_pkg::FLOAT_CMP_CYCLES),
        .RESET_PC         (branch_pkg::RESET_PC)
    ) u_branch_subsystem (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr_kind(instr_kind),
        .branch_opcode(branch_opcode), .branch_offset(branch_offset),
        .operand_a(operand_a), .operand_b(operand_b),
        .pc(pc), .link_pc(link_pc), .stall(stall)
    );

    bind branch_subsystem branch_subsystem_assertions u_assertions (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr_kind(instr_kind),
        .stall(stall), .cmp_busy(cmp_busy), .cmp_start(cmp_start), .advance(advance),
        .save_link(save_link), .int_flag_en(int_flag_en), .float_flag_en(float_flag_en),
        .pc(pc), .link_pc(link_pc)
    );

    function automatic branch_pkg::flag_t int_order(branch_pkg::data_t a, branch_pkg::data_t b);
        if ($signed(a) < $signed(b))
            return branch_pkg::FLAG_LESS;
        else if ($signed(a) > $signed(b))
            return branch_pkg::FLAG_GREATER;
        return branch_pkg::FLAG_EQUAL;
    endfunction

    // maps each float onto an unsigned key that sorts like the real value
    function automatic branch_pkg::flag_t float_order(branch_pkg::data_t a, branch_pkg::data_t b);
        logic [31:0] ka;
        logic [31:0] kb;
        if (((a[30:23] == 8'hff) && (a[22:0] != 0)) || ((b[30:23] == 8'hff) && (b[22:0] != 0)))
            return branch_pkg::FLAG_UNORDERED;
        if (a[30:0] == 0)
            a = '0;
        if (b[30:0] == 0)
            b = '0;
        ka = a[31] ? ~a : (a | 32'h8000_0000);
        kb = b[31] ? ~b : (b | 32'h8000_0000);
        if (ka < kb)
            return branch_pkg::FLAG_LESS;
        else if (ka > kb)
            return branch_pkg::FLAG_GREATER;
        return branch_pkg::FLAG_EQUAL;
    endfunction

    function automatic bit branch_taken(branch_pkg::branch_op_e op, branch_pkg::flag_t f);
        case (op)
            branch_pkg::bne: return f != branch_pkg::FLAG_EQUAL;
            branch_pkg::bg:  return f == branch_pkg::FLAG_GREATER;
            branch_pkg::bl:  return f == branch_pkg::FLAG_LESS;
            branch_pkg::bge: return (f == branch_pkg::FLAG_GREATER) || (f == branch_pkg::FLAG_EQUAL);
            branch_pkg::ble: return (f == branch_pkg::FLAG_LESS) || (f == branch_pkg::FLAG_EQUAL);
            default:         return 1'b0;
        endcase
    endfunction

    function automatic branch_pkg::pc_t rand_offset();
        return branch_pkg::pc_t'(($random(seed) % 16) * 4);
    endfunction

    // retire one instruction in the model
    task automatic apply_model(input branch_pkg::instr_kind_e kind, input branch_pkg::branch_op_e op,
                               input branch_pkg::pc_t offset, input branch_pkg::data_t a,
                               input branch_pkg::data_t b);
        if (kind == branch_pkg::cmp_int)
            exp_flag = int_order(a, b);
        else if (kind == branch_pkg::cmp_float)
            exp_flag = float_order(a, b);
        if (kind != branch_pkg::branch) begin
            exp_pc = exp_pc + 4;
        end else if (op == branch_pkg::jmp) begin
            exp_link = exp_pc + 4;
            exp_pc   = exp_pc + 4 + offset;
        end else if (op == branch_pkg::ret) begin
            exp_pc = exp_link;
        end else begin
            exp_pc = branch_taken(op, exp_flag) ? exp_pc + 4 + offset : exp_pc + 4;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t ns: %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic end_run();
        int assert_fails;
        assert_fails = int'(u_branch_subsystem.u_assertions.fail_count);
        $display("errors: %0d value mismatches, %0d timeouts, %0d assertion failures",
                 errors, timeouts, assert_fails);
        if ((errors == 0) && (timeouts == 0) && (assert_fails == 0))
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic issue(input branch_pkg::instr_kind_e kind, input branch_pkg::branch_op_e op,
                         input branch_pkg::pc_t offset, input branch_pkg::data_t a,
                         input branch_pkg::data_t b, output int stalls);
        int waited;
        waited        = 0;
        instr_valid   = 1'b1;
        instr_kind    = kind;
        branch_opcode = op;
        branch_offset = offset;
        operand_a     = a;
        operand_b     = b;
        #(SETTLE_NS);
        while (stall && (waited < ISSUE_TIMEOUT)) begin
            @(negedge clk);
            #(SETTLE_NS);
            waited++;
        end
        if (stall) begin
            timeouts++;
            $display("timeout: instruction still stalled after %0d cycles at %0t ns",
                     waited, $time);
            stalls = waited;
        end else begin
            stalls = waited;
            @(posedge clk);
            apply_model(kind, op, offset, a, b);
            @(negedge clk);
            check_value("pc", exp_pc, pc);
            check_value("link_pc", exp_link, link_pc);
        end
    endtask

    task automatic idle_cycles(input int n);
        instr_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    // rel 0 equal, 1 a below b, 2 a above b
    task automatic int_pair(input int rel, output branch_pkg::data_t a, output branch_pkg::data_t b);
        branch_pkg::data_t delta;
        a     = branch_pkg::data_t'($random(seed) >>> 2);
        delta = branch_pkg::data_t'(($random(seed) & 255) + 1);
        b     = (rel == 0) ? a : ((rel == 1) ? a + delta : a - delta);
    endtask

    initial begin
        int                stalls;
        int                waited;
        branch_pkg::data_t a;
        branch_pkg::data_t b;
        seed          = 74;
        errors        = 0;
        timeouts      = 0;
        instr_valid   = 1'b0;
        instr_kind    = branch_pkg::other;
        branch_opcode = branch_pkg::bne;
        branch_offset = '0;
        operand_a     = '0;
        operand_b     = '0;
        exp_pc        = branch_pkg::RESET_PC;
        exp_link      = '0;
        exp_flag      = branch_pkg::FLAG_EQUAL;
        waited        = 0;
        while ((rst_n !== 1'b1) && (waited < 10)) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            timeouts++;
            $display("timeout: reset never released");
            end_run();
        end else begin
            @(negedge clk);
            check_value("stall", 32'd0, {31'd0, stall});
            check_value("pc", branch_pkg::RESET_PC, pc);
            repeat (4) issue(branch_pkg::other, branch_pkg::bne, '0, '0, '0, stalls);

            // integer compare then each conditional branch, over eq, lt and gt
            for (int op = 0; op < 5; op++) begin
                for (int rel = 0; rel < 3; rel++) begin
                    int_pair(rel, a, b);
                    issue(branch_pkg::cmp_int, branch_pkg::bne, '0, a, b, stalls);
                    issue(branch_pkg::branch, branch_pkg::branch_op_e'(op), rand_offset(),
                          '0, '0, stalls);
                    check_value("branch stall cycles", branch_pkg::INT_CMP_CYCLES + 1, stalls);
                end
            end

            // a second compare waits out the first, a late branch does not stall
            int_pair(1, a, b);
            issue(branch_pkg::cmp_int, branch_pkg::bne, '0, a, b, stalls);
            issue(branch_pkg::cmp_int, branch_pkg::bne, '0, b, a, stalls);
            check_value("compare stall cycles", branch_pkg::INT_CMP_CYCLES, stalls);
            repeat (3) issue(branch_pkg::other, branch_pkg::bne, '0, '0, '0, stalls);
            issue(branch_pkg::branch, branch_pkg::bg, rand_offset(), '0, '0, stalls);
            check_value("late branch stall cycles", 32'd0, stalls);

            // float compares with nan, signed zeros and ordered values
            for (int op = 0; op < 5; op++) begin
                a = (op % 2 == 0) ? QNAN : branch_pkg::data_t'($random(seed)) & 32'hbfff_ffff;
                b = (op % 2 == 0) ? branch_pkg::data_t'($random(seed)) : QNAN;
                issue(branch_pkg::cmp_float, branch_pkg::bne, '0, a, b, stalls);
                issue(branch_pkg::branch, branch_pkg::branch_op_e'(op), rand_offset(),
                      '0, '0, stalls);
                check_value("float branch stall cycles", branch_pkg::FLOAT_CMP_CYCLES + 1, stalls);
                issue(branch_pkg::cmp_float, branch_pkg::bne, '0, '0, NEG_ZERO, stalls);
                issue(branch_pkg::branch, branch_pkg::branch_op_e'(op), rand_offset(),
                      '0, '0, stalls);
                a = branch_pkg::data_t'($random(seed)) & 32'hbfff_ffff;
                b = branch_pkg::data_t'($random(seed)) & 32'hbfff_ffff;
                issue(branch_pkg::cmp_float, branch_pkg::bne, '0, a, b, stalls);
                issue(branch_pkg::branch, branch_pkg::branch_op_e'(op), rand_offset(),
                      '0, '0, stalls);
            end

            // jump and link, then return
            issue(branch_pkg::branch, branch_pkg::jmp, 32'h40, '0, '0, stalls);
            check_value("jmp stall cycles", 32'd0, stalls);
            repeat (2) issue(branch_pkg::other, branch_pkg::bne, '0, '0, '0, stalls);
            issue(branch_pkg::branch, branch_pkg::ret, rand_offset(), '0, '0, stalls);

            // reserved falls through, idle cycles keep pc still
            issue(branch_pkg::branch, branch_pkg::reserved, rand_offset(), '0, '0, stalls);
            idle_cycles(3);
            check_value("pc", exp_pc, pc);
            issue(branch_pkg::other, branch_pkg::bne, '0, '0, '0, stalls);
            idle_cycles(2);
            end_run();
        end
    end

endmodule

`default_nettype wire

//--- sources.f
source/branch_pkg.sv
source/compare_unit.sv
source/branch_unit.sv
source/pc_sequencer.sv
source/branch_subsystem.sv
testbench/tb_clock_gen.sv
testbench/branch_subsystem_assertions.sv
testbench/branch_subsystem_tb.sv

//--- Makefile
# build and run with Verilator, the result line in sim.log decides pass or fail

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module branch_subsystem_tb -f sources.f -Mdir obj_dir
	./obj_dir/Vbranch_subsystem_tb +verilator+error+limit+1000 | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
